// ==== design/bch_pkg.sv ====
`default_nettype none

package bch_pkg;

    // code and field sizes
    localparam int CODE_N  = 15;
    localparam int MSG_K   = 7;
    localparam int GEN_DEG = 8;
    localparam int GF_M    = 4;

    // g(x) = x^8 + x^7 + x^6 + x^4 + 1
    localparam logic [GEN_DEG:0] GEN_POLY  = 9'b111010001;
    localparam logic [GF_M:0]    PRIM_POLY = 5'b10011; // x^4 + x + 1

    typedef logic [CODE_N-1:0] codeword_t;
    typedef logic [MSG_K-1:0]  message_t;
    typedef logic [GF_M-1:0]   gf_elem_t;
    typedef logic [1:0]        err_count_t;

    typedef enum logic [2:0] {
        SEQ_IDLE     = 3'h0,
        SEQ_ENCODE   = 3'h1,
        SEQ_INJECT   = 3'h2,
        SEQ_SYNDROME = 3'h3,
        SEQ_LOCATE   = 3'h4,
        SEQ_RECOVER  = 3'h5,
        SEQ_DONE     = 3'h6
    } seq_state_t;

    // ----------------------------------------------------------------------
    // GF(16) arithmetic
    // ----------------------------------------------------------------------
    function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
        gf_elem_t prod;
        gf_elem_t x;
        prod = '0;
        x    = a;
        for (int i = 0; i < GF_M; i++)
        begin
            if (b[i])
                prod = prod ^ x;
            // multiply x by alpha, reduce on overflow
            x = x[GF_M-1] ? ((x << 1) ^ PRIM_POLY[GF_M-1:0]) : (x << 1);
        end
        return prod;
    endfunction

    // a^-1 = a^14 in GF(16), zero maps to zero
    function automatic gf_elem_t gf_inv(input gf_elem_t a);
        gf_elem_t r;
        r = a;
        for (int i = 0; i < CODE_N - 2; i++)
            r = gf_mul(r, a);
        return r;
    endfunction

    function automatic gf_elem_t gf_alpha_pow(input int unsigned e);
        gf_elem_t r;
        r = gf_elem_t'(1);
        for (int i = 0; i < CODE_N; i++)
        begin
            if (i < (e % CODE_N))
                r = gf_mul(r, gf_elem_t'(2)); // alpha is x
        end
        return r;
    endfunction

endpackage

`default_nettype wire

// ==== design/bch_encoder.sv ====
`default_nettype none

module bch_encoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               go,
    input  bch_pkg::message_t  message,
    output bch_pkg::codeword_t codeword,
    output logic               enc_done
);
    import bch_pkg::*;

    localparam int IDX_W = $clog2(MSG_K);

    logic [IDX_W-1:0] bit_idx;  // message bit under work
    logic             running;
    codeword_t        acc;

    // step control
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            running  <= 1'b0;
            bit_idx  <= '0;
            enc_done <= 1'b0;
        end
        else
        begin
            enc_done <= 1'b0;
            if (go)
            begin
                running <= 1'b1;
                bit_idx <= '0;
            end
            else if (running)
            begin
                if (bit_idx == MSG_K - 1)
                begin
                    running  <= 1'b0;
                    enc_done <= 1'b1;
                end
                bit_idx <= bit_idx + 1'b1;
            end
        end
    end

    // c(x) = m(x) * g(x), one partial product per cycle
    always_ff @(posedge clk)
    begin
        if (go)
            acc <= '0;
        else if (running && message[bit_idx])
            acc <= acc ^ (codeword_t'(GEN_POLY) << bit_idx);
    end

    assign codeword = acc;

endmodule

`default_nettype wire

// ==== design/bch_syndrome_calc.sv ====
`default_nettype none

module bch_syndrome_calc (
    input  logic               clk,
    input  logic               rst,
    input  logic               go,
    input  bch_pkg::codeword_t received,
    output bch_pkg::gf_elem_t  s1,
    output bch_pkg::gf_elem_t  s3,
    output logic               syn_zero,
    output logic               syn_done
);
    import bch_pkg::*;

    localparam int       IDX_W   = $clog2(CODE_N);
    localparam gf_elem_t ALPHA_1 = gf_alpha_pow(1);
    localparam gf_elem_t ALPHA_3 = gf_alpha_pow(3);

    logic [IDX_W-1:0] idx;     // walks from the top coefficient down
    logic             running;
    gf_elem_t         r_bit;

    assign r_bit = gf_elem_t'(received[idx]);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            running  <= 1'b0;
            idx      <= '0;
            syn_done <= 1'b0;
        end
        else
        begin
            syn_done <= 1'b0;
            if (go)
            begin
                running <= 1'b1;
                idx     <= IDX_W'(CODE_N - 1);
            end
            else if (running)
            begin
                if (idx == '0)
                begin
                    running  <= 1'b0;
                    syn_done <= 1'b1;
                end
                idx <= idx - 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Horner: s = s * beta + r_i, ends at r(alpha) and r(alpha^3)
    // ----------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (go)
        begin
            s1 <= '0;
            s3 <= '0;
        end
        else if (running)
        begin
            s1 <= gf_mul(s1, ALPHA_1) ^ r_bit;
            s3 <= gf_mul(s3, ALPHA_3) ^ r_bit;
        end
    end

    assign syn_zero = (s1 == '0) && (s3 == '0);

endmodule

`default_nettype wire

// ==== design/bch_error_locator.sv ====
`default_nettype none

module bch_error_locator #(
    parameter int MAX_ERRORS = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                go,
    input  bch_pkg::gf_elem_t   s1,
    input  bch_pkg::gf_elem_t   s3,
    output bch_pkg::codeword_t  error_mask,
    output bch_pkg::err_count_t err_count,
    output logic                loc_fail,
    output logic                loc_done
);
    import bch_pkg::*;

    typedef enum logic [1:0] {
        LOC_IDLE   = 2'h0,
        LOC_CHIEN  = 2'h1,
        LOC_RESULT = 2'h2
    } loc_phase_t;

    localparam int       POS_W      = $clog2(CODE_N);
    localparam gf_elem_t ALPHA_INV1 = gf_alpha_pow(CODE_N - 1); // alpha^-1
    localparam gf_elem_t ALPHA_INV2 = gf_alpha_pow(CODE_N - 2); // alpha^-2

    loc_phase_t       phase;
    logic [POS_W-1:0] pos;
    gf_elem_t         s1_cubed;
    gf_elem_t         sigma2_next;
    err_count_t       degree_next;
    logic             early_fail;
    gf_elem_t         term1_q;     // sigma1 * alpha^-i
    gf_elem_t         term2_q;     // sigma2 * alpha^-2i
    gf_elem_t         chien_sum;
    err_count_t       degree_q;
    err_count_t       roots;
    logic             fail_q;

    // ----------------------------------------------------------------------
    // Peterson solution for t = 2: sigma1 = S1, sigma2 = (S3 + S1^3) / S1
    // ----------------------------------------------------------------------
    assign s1_cubed    = gf_mul(gf_mul(s1, s1), s1);
    assign sigma2_next = (MAX_ERRORS > 1) ? gf_mul(s3 ^ s1_cubed, gf_inv(s1)) : '0;
    assign early_fail  = (MAX_ERRORS > 1) && (s1 == '0) && (s3 != '0);
    assign degree_next = (sigma2_next != '0) ? 2'd2 : ((s1 != '0) ? 2'd1 : 2'd0);

    // sigma(alpha^-i) = 1 + term1 + term2
    assign chien_sum = gf_elem_t'(1) ^ term1_q ^ term2_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            phase     <= LOC_IDLE;
            pos       <= '0;
            roots     <= '0;
            fail_q    <= 1'b0;
            err_count <= '0;
            loc_fail  <= 1'b0;
            loc_done  <= 1'b0;
        end
        else
        begin
            loc_done <= 1'b0;
            if (go)
            begin
                phase     <= LOC_CHIEN;
                pos       <= '0;
                roots     <= '0;
                fail_q    <= early_fail;
                err_count <= '0;
                loc_fail  <= 1'b0;
            end
            else
            begin
                case (phase)
                    LOC_CHIEN:
                    begin
                        if (chien_sum == '0)
                            roots <= roots + 2'd1;
                        if (pos == CODE_N - 1)
                            phase <= LOC_RESULT;
                        pos <= pos + 1'b1;
                    end
                    LOC_RESULT:
                    begin
                        err_count <= roots;
                        loc_fail  <= fail_q || (roots != degree_q); // missing roots
                        loc_done  <= 1'b1;
                        phase     <= LOC_IDLE;
                    end
                    default: phase <= LOC_IDLE;
                endcase
            end
        end
    end

    // search datapath
    always_ff @(posedge clk)
    begin
        if (go)
        begin
            term1_q    <= s1;
            term2_q    <= sigma2_next;
            degree_q   <= degree_next;
            error_mask <= '0;
        end
        else if (phase == LOC_CHIEN)
        begin
            term1_q         <= gf_mul(term1_q, ALPHA_INV1);
            term2_q         <= gf_mul(term2_q, ALPHA_INV2);
            error_mask[pos] <= (chien_sum == '0);
        end
    end

endmodule

`default_nettype wire

// ==== design/bch_message_recover.sv ====
`default_nettype none

module bch_message_recover (
    input  logic               clk,
    input  logic               rst,
    input  logic               go,
    input  bch_pkg::codeword_t corrected,
    output bch_pkg::message_t  message_out,
    output logic               rec_done
);
    import bch_pkg::*;

    localparam int STEP_W = $clog2(MSG_K);

    logic [STEP_W-1:0] step;    // quotient bit under work
    logic              running;
    codeword_t         rem_q;
    message_t          quot_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            running  <= 1'b0;
            step     <= '0;
            rec_done <= 1'b0;
        end
        else
        begin
            rec_done <= 1'b0;
            if (go)
            begin
                running <= 1'b1;
                step    <= STEP_W'(MSG_K - 1);
            end
            else if (running)
            begin
                if (step == '0)
                begin
                    running  <= 1'b0;
                    rec_done <= 1'b1;
                end
                step <= step - 1'b1;
            end
        end
    end

    // long division, top quotient bit first
    always_ff @(posedge clk)
    begin
        if (go)
        begin
            rem_q  <= corrected;
            quot_q <= '0;
        end
        else if (running && rem_q[step + GEN_DEG])
        begin
            quot_q[step] <= 1'b1;
            rem_q        <= rem_q ^ (codeword_t'(GEN_POLY) << step);
        end
    end

    assign message_out = quot_q;

endmodule

`default_nettype wire

// ==== design/bch_sequencer.sv ====
`default_nettype none

module bch_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic enc_done,
    input  logic syn_done,
    input  logic syn_zero,
    input  logic loc_done,
    input  logic rec_done,
    output logic enc_go,
    output logic inject,
    output logic syn_go,
    output logic loc_go,
    output logic rec_go,
    output logic skip_locate,
    output logic busy,
    output logic done
);
    import bch_pkg::*;

    seq_state_t state;
    logic       accept;

    assign accept = start && !busy; // start while busy is dropped

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state       <= SEQ_IDLE;
            enc_go      <= 1'b0;
            inject      <= 1'b0;
            syn_go      <= 1'b0;
            loc_go      <= 1'b0;
            rec_go      <= 1'b0;
            skip_locate <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
        end
        else
        begin
            // strobes last one cycle
            enc_go <= 1'b0;
            inject <= 1'b0;
            syn_go <= 1'b0;
            loc_go <= 1'b0;
            rec_go <= 1'b0;
            done   <= 1'b0;

            case (state)
                SEQ_IDLE, SEQ_DONE:
                begin
                    if (accept)
                    begin
                        state       <= SEQ_ENCODE;
                        enc_go      <= 1'b1;
                        busy        <= 1'b1;
                        skip_locate <= 1'b0;
                    end
                    else
                        state <= SEQ_IDLE;
                end
                SEQ_ENCODE:
                begin
                    if (enc_done)
                    begin
                        state  <= SEQ_INJECT;
                        inject <= 1'b1;
                    end
                end
                SEQ_INJECT:
                begin
                    state  <= SEQ_SYNDROME;
                    syn_go <= 1'b1;
                end
                SEQ_SYNDROME:
                begin
                    if (syn_done)
                    begin
                        skip_locate <= syn_zero;
                        if (syn_zero)
                        begin
                            state  <= SEQ_RECOVER; // clean word, no search
                            rec_go <= 1'b1;
                        end
                        else
                        begin
                            state  <= SEQ_LOCATE;
                            loc_go <= 1'b1;
                        end
                    end
                end
                SEQ_LOCATE:
                begin
                    if (loc_done)
                    begin
                        state  <= SEQ_RECOVER;
                        rec_go <= 1'b1;
                    end
                end
                SEQ_RECOVER:
                begin
                    if (rec_done)
                    begin
                        state <= SEQ_DONE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/bch_codec_top.sv ====
`default_nettype none

module bch_codec_top #(
    parameter int MAX_ERRORS = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  bch_pkg::message_t   message,
    input  bch_pkg::codeword_t  error_pattern,
    output logic                busy,
    output logic                done,
    output bch_pkg::codeword_t  codeword,
    output bch_pkg::message_t   corrected_message,
    output bch_pkg::err_count_t error_count,
    output logic                uncorrectable
);
    import bch_pkg::*;

    logic       enc_go;
    logic       enc_done;
    logic       inject;
    logic       syn_go;
    logic       syn_done;
    logic       syn_zero;
    logic       loc_go;
    logic       loc_done;
    logic       loc_fail;
    logic       rec_go;
    logic       rec_done;
    logic       skip_locate;
    logic       accept;
    message_t   msg_q;
    codeword_t  pattern_q;
    codeword_t  received_q;
    codeword_t  corrected;
    codeword_t  error_mask;
    gf_elem_t   s1;
    gf_elem_t   s3;
    err_count_t err_count;

    // ----------------------------------------------------------------------
    // input capture and channel model
    // ----------------------------------------------------------------------
    assign accept = start && !busy;

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            msg_q     <= message;
            pattern_q <= error_pattern;
        end
    end

    always_ff @(posedge clk)
    begin
        if (inject)
            received_q <= codeword ^ pattern_q;
    end

    // stale locator results are masked off on the skip path
    assign corrected     = received_q ^ (skip_locate ? '0 : error_mask);
    assign error_count   = skip_locate ? '0 : err_count;
    assign uncorrectable = skip_locate ? 1'b0 : loc_fail;

    bch_sequencer i_bch_sequencer (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .enc_done    (enc_done),
        .syn_done    (syn_done),
        .syn_zero    (syn_zero),
        .loc_done    (loc_done),
        .rec_done    (rec_done),
        .enc_go      (enc_go),
        .inject      (inject),
        .syn_go      (syn_go),
        .loc_go      (loc_go),
        .rec_go      (rec_go),
        .skip_locate (skip_locate),
        .busy        (busy),
        .done        (done)
    );

    bch_encoder i_bch_encoder (
        .clk      (clk),
        .rst      (rst),
        .go       (enc_go),
        .message  (msg_q),
        .codeword (codeword),
        .enc_done (enc_done)
    );

    bch_syndrome_calc i_bch_syndrome_calc (
        .clk      (clk),
        .rst      (rst),
        .go       (syn_go),
        .received (received_q),
        .s1       (s1),
        .s3       (s3),
        .syn_zero (syn_zero),
        .syn_done (syn_done)
    );

    bch_error_locator #(
        .MAX_ERRORS (MAX_ERRORS)
    ) i_bch_error_locator (
        .clk        (clk),
        .rst        (rst),
        .go         (loc_go),
        .s1         (s1),
        .s3         (s3),
        .error_mask (error_mask),
        .err_count  (err_count),
        .loc_fail   (loc_fail),
        .loc_done   (loc_done)
    );

    bch_message_recover i_bch_message_recover (
        .clk         (clk),
        .rst         (rst),
        .go          (rec_go),
        .corrected   (corrected),
        .message_out (corrected_message),
        .rec_done    (rec_done)
    );

endmodule

`default_nettype wire

// ==== verif/bch_codec_tb.sv ====
`default_nettype none

module bch_codec_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import bch_pkg::*;

    localparam int          CLK_PERIOD      = 8;
    localparam int          DRIVE_DELAY     = 1;
    localparam int          RESET_CYCLES    = 8;
    localparam int          NUM_WORDS       = 20;
    localparam int          CYCLES_PER_WORD = 60;
    localparam int          CYCLE_LIMIT     = NUM_WORDS * CYCLES_PER_WORD;
    localparam logic [31:0] SEED            = 32'h1b754292;

    logic       clk;
    logic       rst;
    logic       start;
    message_t   message;
    codeword_t  error_pattern;
    logic       busy;
    logic       done;
    codeword_t  codeword;
    message_t   corrected_message;
    err_count_t error_count;
    logic       uncorrectable;

    // expectations for the word in flight
    logic       expect_done;
    logic       beyond_limit;  // three errors, success must not be claimed
    logic       started;
    message_t   exp_msg;
    codeword_t  exp_cw;
    err_count_t exp_errs;

    int mismatches;
    int done_seen;
    int done_mark;
    int cycle_count;
    int tests_run;
    int tests_failed;
    int test_base;

    bch_codec_top #(
        .MAX_ERRORS (2)
    ) i_bch_codec_top (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .message           (message),
        .error_pattern     (error_pattern),
        .busy              (busy),
        .done              (done),
        .codeword          (codeword),
        .corrected_message (corrected_message),
        .error_count       (error_count),
        .uncorrectable     (uncorrectable)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog, ends a run that stops making progress
    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the run did not complete", CYCLE_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ----------------------------------------------------------------------
    // checker, samples mid-cycle when all outputs have settled
    // ----------------------------------------------------------------------
    always @(negedge clk)
    begin
        if (!rst && !started)
        begin
            assert (!busy && !done)
            else
            begin
                $display("busy or done went high before the first start");
                mismatches++;
            end
        end
        if (!rst && done)
        begin
            assert (!busy) // busy drops on the edge that raises done
            else
            begin
                $display("[ERROR] busy: got %h, expected %h", busy, 1'b0);
                mismatches++;
            end
            assert (expect_done)
            else
            begin
                $display("done pulsed with no word in flight");
                mismatches++;
            end
            if (expect_done)
            begin
                assert (codeword == exp_cw)
                else
                begin
                    $display("[ERROR] codeword: got %h, expected %h", codeword, exp_cw);
                    mismatches++;
                end
                if (beyond_limit)
                begin
                    assert (uncorrectable || (corrected_message != exp_msg))
                    else
                    begin
                        $display("three-error word was reported as fully corrected");
                        mismatches++;
                    end
                end
                else
                begin
                    assert (corrected_message == exp_msg)
                    else
                    begin
                        $display("[ERROR] corrected_message: got %h, expected %h",
                                 corrected_message, exp_msg);
                        mismatches++;
                    end
                    assert (error_count == exp_errs)
                    else
                    begin
                        $display("[ERROR] error_count: got %h, expected %h",
                                 error_count, exp_errs);
                        mismatches++;
                    end
                    assert (!uncorrectable)
                    else
                    begin
                        $display("[ERROR] uncorrectable: got %h, expected %h",
                                 uncorrectable, 1'b0);
                        mismatches++;
                    end
                end
            end
            expect_done = 1'b0;
            done_seen++;
        end
    end

    // ----------------------------------------------------------------------
    // reference model and stimulus helpers
    // ----------------------------------------------------------------------
    // c(x) = m(x) * g(x) over GF(2), each coefficient c_j = sum of m_i * g_(j-i)
    task automatic encode_reference(input message_t m, output codeword_t c);
        c = '0;
        for (int j = 0; j < CODE_N; j++)
        begin
            for (int i = 0; i < MSG_K; i++)
            begin
                if ((j - i >= 0) && (j - i <= GEN_DEG))
                    c[j] = c[j] ^ (m[i] & GEN_POLY[j - i]);
            end
        end
    endtask

    task automatic random_pattern(input int nbits, output codeword_t p);
        int          placed;
        int unsigned pos;
        p      = '0;
        placed = 0;
        while (placed < nbits)
        begin
            pos = $urandom % CODE_N;
            if (!p[pos])
            begin
                p[pos] = 1'b1;
                placed++;
            end
        end
    endtask

    // one-cycle start pulse, called just after a rising edge
    task automatic drive_start(input message_t m, input codeword_t p);
        start         = 1'b1;
        message       = m;
        error_pattern = p;
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
    endtask

    task automatic issue_word(input message_t m, input codeword_t p, input int nerr);
        codeword_t cw;
        encode_reference(m, cw);
        exp_msg      = m;
        exp_cw       = cw;
        exp_errs     = err_count_t'(nerr);
        beyond_limit = (nerr > 2);
        expect_done  = 1'b1;
        started      = 1'b1;
        done_mark    = done_seen;
        drive_start(m, p);
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while ((done_seen == done_mark) && (waited < CYCLES_PER_WORD))
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (done_seen == done_mark)
        begin
            $display("no done within %0d cycles of start", CYCLES_PER_WORD);
            mismatches++;
            expect_done = 1'b0;
        end
    endtask

    task automatic run_words(input int count, input int nerr);
        codeword_t p;
        for (int w = 0; w < count; w++)
        begin
            random_pattern(nerr, p);
            issue_word(message_t'($urandom), p, nerr);
            wait_done();
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (mismatches == test_base)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d check(s) failed", tests_run, name,
                     mismatches - test_base);
        end
        test_base = mismatches;
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial
    begin
        codeword_t p;
        message_t  m;
        int        base;
        void'($urandom(SEED));
        rst           = 1'b1;
        start         = 1'b0;
        message       = '0;
        error_pattern = '0;
        expect_done   = 1'b0;
        beyond_limit  = 1'b0;
        started       = 1'b0;
        exp_msg       = '0;
        exp_cw        = '0;
        exp_errs      = '0;
        mismatches    = 0;
        done_seen     = 0;
        done_mark     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        test_base     = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        repeat (4) @(posedge clk); // idle, checker watches busy and done
        #DRIVE_DELAY;
        finish_test("idle after reset");

        run_words(3, 0);
        finish_test("no errors");
        run_words(5, 1);
        finish_test("one error");
        run_words(5, 2);
        finish_test("two errors");
        run_words(4, 3);
        finish_test("three errors");

        // second start lands while the first word is still in flight
        m = message_t'($urandom);
        random_pattern(1, p);
        base = done_seen;
        issue_word(m, p, 1);
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        random_pattern(2, p);
        drive_start(~m, p);
        wait_done();
        repeat (CYCLES_PER_WORD) @(posedge clk); // a late second done would show here
        #DRIVE_DELAY;
        assert (done_seen == base + 1)
        else
        begin
            $display("start while busy gave %0d done pulses instead of one", done_seen - base);
            mismatches++;
        end
        finish_test("start while busy");

        $display("tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if ((tests_failed == 0) && (mismatches == 0))
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bch_codec_top.f ====
design/bch_pkg.sv
design/bch_encoder.sv
design/bch_syndrome_calc.sv
design/bch_error_locator.sv
design/bch_message_recover.sv
design/bch_sequencer.sv
design/bch_codec_top.sv
verif/bch_codec_tb.sv
